// File: files.f
source/eth_tx_pkg.sv
source/tx_reg_port.sv
source/tx_fifo.sv
source/tx_pop_ctrl.sv
source/tx_beat_format.sv
source/eth_tx_buffer.sv
tb/tb_clock_gen.sv
tb/tb_eth_tx_buffer.sv

// File: tb/tb_eth_tx_buffer.sv
`timescale 1ns/1ps

module tb_eth_tx_buffer import eth_tx_pkg::*; ();

	//////////////////////////////////////////////////
	// Run limits

	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 4;
	// Idle window used to show that the output stays quiet
	localparam int QUIET_CYCLES = 12;
	// Rough per-test budgets, two cycles per bus access plus drain time
	localparam int T1_CYCLES    = 20;
	localparam int T2_CYCLES    = 60;
	localparam int T3_CYCLES    = 80;
	localparam int T4_CYCLES    = 120;
	localparam int T5_CYCLES    = 300;
	localparam int T6_CYCLES    = 150;
	localparam int MARGIN       = 200;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
		+ T4_CYCLES + T5_CYCLES + T6_CYCLES + MARGIN;

	// DUT ports
	logic     tx_clk;
	logic     rst_n;
	logic     link_up;
	reg_req_t req;
	reg_rsp_t rsp;
	logic     credit_return;
	logic     out_valid;
	tx_beat_t out_beat;

	// Reference model, beats of the open frame and beats already committed
	tx_beat_t exp_q[$];
	tx_beat_t pend_q[$];
	int       frame_len = 0;
	int       frame_left = 0;

	// Output mirror, refreshed on the falling edge
	logic     mon_valid = 1'b0;
	tx_beat_t mon_beat = '0;
	logic     exp_avail = 1'b0;
	tx_beat_t exp_head = '0;
	int       beats_seen = 0;
	// Beats sent and not yet credited back
	int       outstanding = 0;

	// Credit return control
	logic     auto_credit = 1'b1;
	int       credit_req = 0;

	// Bookkeeping
	int       errors = 0;
	int       errors_at_start = 0;
	int       tests_run = 0;
	int       tests_failed = 0;
	int       cycle_count = 0;
	integer   seed = 32'h1cd257af;

	tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
		.tx_clk (tx_clk),
		.rst_n  (rst_n)
	);

	eth_tx_buffer UUT (
		.tx_clk        (tx_clk),
		.rst_n         (rst_n),
		.link_up       (link_up),
		.req           (req),
		.rsp           (rsp),
		.credit_return (credit_return),
		.out_valid     (out_valid),
		.out_beat      (out_beat)
	);

	//////////////////////////////////////////////////
	// Output monitor and checks

	// Outputs are stable mid cycle
	always @(negedge tx_clk) begin
		mon_valid = out_valid;
		mon_beat  = out_beat;
		exp_avail = (exp_q.size() != 0);
		if (out_valid) begin
			beats_seen++;
			outstanding++;
			if (exp_avail)
				exp_head = exp_q.pop_front();
		end
		if (credit_return)
			outstanding--;
	end

	// Every beat must have been predicted
	assert property (@(posedge tx_clk) disable iff (!rst_n) mon_valid |-> exp_avail)
		else begin
			errors++;
			$display("Beat appeared on the output with no beat expected, data %h", mon_beat.data);
		end

	// Data, keep and last against the head of the reference queue
	assert property (@(posedge tx_clk) disable iff (!rst_n)
		(mon_valid && exp_avail) |-> (mon_beat == exp_head))
		else begin
			errors++;
			$display("CHECK FAILED out_beat got %h expected %h", mon_beat, exp_head);
		end

	// MAC never holds more beats than it has room for
	assert property (@(posedge tx_clk) disable iff (!rst_n) outstanding <= TX_CREDITS)
		else begin
			errors++;
			$display("CHECK FAILED outstanding got %h limit %h", outstanding, TX_CREDITS);
		end

	//////////////////////////////////////////////////
	// Credit driver and timeout

	// Manual requests first, otherwise hand back whatever is outstanding
	always @(posedge tx_clk) begin
		#DRIVE_DELAY;
		if (rst_n && (credit_req > 0)) begin
			credit_return = 1'b1;
			credit_req--;
		end else if (rst_n && auto_credit && (outstanding > 0)) begin
			credit_return = 1'b1;
		end else begin
			credit_return = 1'b0;
		end
	end

	always @(posedge tx_clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp)
		else begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// Expected beat by rule, keep and data cut to nbytes
	function automatic tx_beat_t make_beat(input logic [31:0] data, input int nbytes);
		tx_beat_t b;
		b.keep = 4'hf >> (4 - nbytes);
		b.data = data & (32'hffff_ffff >> (8 * (4 - nbytes)));
		b.last = 1'b0;
		return b;
	endfunction

	// Single cycle access, response checked mid cycle
	task automatic bus_access(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, input logic exp_err, input logic check_rdata,
			input logic [31:0] exp_rdata);
		@(posedge tx_clk);
		#DRIVE_DELAY;
		req.sel    = 1'b1;
		req.enable = 1'b1;
		req.write  = write;
		req.addr   = addr;
		req.wdata  = wdata;
		@(negedge tx_clk);
		compare_value("rsp.ready", 32'(rsp.ready), 32'h1);
		compare_value("rsp.slverr", 32'(rsp.slverr), 32'(exp_err));
		if (check_rdata)
			compare_value("rsp.rdata", rsp.rdata, exp_rdata);
		@(posedge tx_clk);
		#DRIVE_DELAY;
		req = '0;
	endtask

	task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp_rdata,
			input logic exp_err);
		bus_access(1'b0, addr, 32'h0, exp_err, !exp_err, exp_rdata);
	endtask

	task automatic set_length(input int len);
		bus_access(1'b1, REG_LENGTH, 32'(len), 1'b0, 1'b0, 32'h0);
		frame_len  = len;
		frame_left = len;
	endtask

	// Window offset sets the byte count, past the frame end nothing is stored
	task automatic buf_write(input int offset, input logic [31:0] data);
		int n;
		bus_access(1'b1, REG_TX_BUF + 8'(offset), data, 1'b0, 1'b0, 32'h0);
		if (offset < frame_len) begin
			n = ((frame_len - offset) >= 4) ? 4 : (frame_len - offset);
			pend_q.push_back(make_beat(data, n));
		end
	endtask

	// Sequential words consume the remaining byte count
	task automatic word_write(input logic [31:0] data);
		int n;
		bus_access(1'b1, REG_TX_WORD, data, 1'b0, 1'b0, 32'h0);
		if (frame_left > 0) begin
			n = (frame_left >= 4) ? 4 : frame_left;
			frame_left -= n;
			pend_q.push_back(make_beat(data, n));
		end
	endtask

	task automatic commit_frame();
		tx_beat_t b;
		bus_access(1'b1, REG_COMMIT, 32'h0, 1'b0, 1'b0, 32'h0);
		// Empty frames never reach the output
		if (pend_q.size() != 0) begin
			b = pend_q.pop_back();
			b.last = 1'b1;
			pend_q.push_back(b);
			foreach (pend_q[i])
				exp_q.push_back(pend_q[i]);
			pend_q.delete();
		end
		frame_len  = 0;
		frame_left = 0;
	endtask

	task automatic wait_beats(input int target);
		while (beats_seen < target)
			@(posedge tx_clk);
	endtask

	// All predicted beats out and all credits home
	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge tx_clk);
		while (outstanding != 0)
			@(posedge tx_clk);
		repeat (2) @(posedge tx_clk);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: FAILED", tests_run, name);
		end
		errors_at_start = errors;
	endtask

	//////////////////////////////////////////////////
	// Stimulus

	initial begin
		int start;
		int len;
		int words_total;
		req           = '0;
		link_up       = 1'b1;
		credit_return = 1'b0;
		words_total   = 0;
		@(posedge rst_n);

		// Status read, status write, read of a write only register
		read_reg(REG_STAT, 32'h1, 1'b0);
		bus_access(1'b1, REG_STAT, 32'h1, 1'b1, 1'b0, 32'h0);
		read_reg(REG_LENGTH, 32'h0, 1'b1);
		report_test("register access");

		// Ten bytes through the buffer window
		start = beats_seen;
		set_length(10);
		buf_write(0, 32'h11223344);
		buf_write(4, 32'h55667788);
		buf_write(8, 32'h99aabbcc);
		commit_frame();
		wait_drain();
		compare_value("beats_seen", beats_seen - start, 3);
		report_test("buffer window frame");

		// Five bytes, third word falls past the end
		start = beats_seen;
		set_length(5);
		word_write($random(seed));
		word_write($random(seed));
		word_write($random(seed));
		commit_frame();
		wait_drain();
		commit_frame();
		repeat (QUIET_CYCLES) @(posedge tx_clk);
		compare_value("beats_seen", beats_seen - start, 2);
		report_test("word register frame");

		// Eight words with credits held back
		start = beats_seen;
		auto_credit = 1'b0;
		set_length(32);
		for (int i = 0; i < 8; i++)
			word_write($random(seed));
		commit_frame();
		wait_beats(start + TX_CREDITS);
		repeat (QUIET_CYCLES) @(posedge tx_clk);
		compare_value("beats_seen", beats_seen - start, TX_CREDITS);
		// One credit releases exactly one more beat
		for (int i = 0; i < 8 - TX_CREDITS; i++) begin
			@(negedge tx_clk);
			credit_req = 1;
			wait_beats(start + TX_CREDITS + i + 1);
		end
		auto_credit = 1'b1;
		wait_drain();
		compare_value("beats_seen", beats_seen - start, 8);
		report_test("credit back-pressure");

		// Random frames queued back to back
		start = beats_seen;
		for (int f = 0; f < 4; f++) begin
			len = 1 + ($unsigned($random(seed)) % 20);
			set_length(len);
			for (int w = 0; w < (len + 3) / 4; w++)
				word_write($random(seed));
			commit_frame();
			words_total += (len + 3) / 4;
		end
		wait_drain();
		compare_value("beats_seen", beats_seen - start, words_total);
		report_test("multiple random frames");

		// Stall a frame on credits, then take the link down
		start = beats_seen;
		auto_credit = 1'b0;
		set_length(24);
		for (int i = 0; i < 6; i++)
			word_write($random(seed));
		commit_frame();
		wait_beats(start + TX_CREDITS);
		@(posedge tx_clk);
		#DRIVE_DELAY;
		link_up = 1'b0;
		// Flushed words are never sent
		exp_q.delete();
		read_reg(REG_STAT, 32'h0, 1'b0);
		repeat (QUIET_CYCLES) @(posedge tx_clk);
		compare_value("beats_seen", beats_seen - start, TX_CREDITS);
		// Credits spent before the drop come back anyway
		@(negedge tx_clk);
		credit_req = TX_CREDITS;
		while (outstanding != 0)
			@(posedge tx_clk);
		@(posedge tx_clk);
		#DRIVE_DELAY;
		link_up     = 1'b1;
		auto_credit = 1'b1;
		start = beats_seen;
		set_length(7);
		buf_write(0, $random(seed));
		buf_write(4, $random(seed));
		commit_frame();
		wait_drain();
		compare_value("beats_seen", beats_seen - start, 2);
		report_test("link down flush");

		$display("Tests run: %0d, tests failed: %0d, check errors: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 4
) (
	output logic tx_clk,
	output logic rst_n
);

	// 20 ns period
	initial begin
		tx_clk = 1'b0;
		forever #10 tx_clk = ~tx_clk;
	end

	// Reset held over the first rising edges, released just after one
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge tx_clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

// File: source/eth_tx_buffer.sv
`timescale 1ns/1ps

module eth_tx_buffer import eth_tx_pkg::*; (
	input  logic     tx_clk,
	input  logic     rst_n,
	input  logic     link_up,
	input  reg_req_t req,
	output reg_rsp_t rsp,
	input  logic     credit_return,
	output logic     out_valid,
	output tx_beat_t out_beat
);

	// Link down empties both queues
	logic     flush;

	// Word path
	logic     word_wr_en;
	tx_word_t word_wr;
	logic     data_full;
	logic     data_rd_en;
	tx_word_t word_rd;
	logic     data_empty;

	// Frame length path
	logic     len_wr_en;
	tx_len_t  len_wr;
	logic     len_rd_en;
	tx_len_t  len_rd;
	logic     len_empty;

	// Controller to formatter
	logic     word_taken;
	logic     last_word;

	assign flush = !link_up;

	//////////////////////////////////////////////////
	// Host side

	tx_reg_port u_reg_port (
		.tx_clk     (tx_clk),
		.rst_n      (rst_n),
		.req        (req),
		.rsp        (rsp),
		.link_up    (link_up),
		.data_full  (data_full),
		.word_wr_en (word_wr_en),
		.word_wr    (word_wr),
		.len_wr_en  (len_wr_en),
		.len_wr     (len_wr)
	);

	//////////////////////////////////////////////////
	// Queues

	tx_fifo #(.T(tx_word_t), .DEPTH(DATA_FIFO_DEPTH)) u_data_fifo (
		.tx_clk  (tx_clk),
		.rst_n   (rst_n),
		.flush   (flush),
		.wr_en   (word_wr_en),
		.wr_data (word_wr),
		.full    (data_full),
		.rd_en   (data_rd_en),
		.rd_data (word_rd),
		.empty   (data_empty)
	);

	// Host never sees length FIFO full, frames beyond its depth are a usage error
	tx_fifo #(.T(tx_len_t), .DEPTH(LEN_FIFO_DEPTH)) u_len_fifo (
		.tx_clk  (tx_clk),
		.rst_n   (rst_n),
		.flush   (flush),
		.wr_en   (len_wr_en),
		.wr_data (len_wr),
		.full    (),
		.rd_en   (len_rd_en),
		.rd_data (len_rd),
		.empty   (len_empty)
	);

	//////////////////////////////////////////////////
	// MAC side

	tx_pop_ctrl u_pop_ctrl (
		.tx_clk        (tx_clk),
		.rst_n         (rst_n),
		.link_up       (link_up),
		.len_empty     (len_empty),
		.len_rd_en     (len_rd_en),
		.len_rd        (len_rd),
		.data_empty    (data_empty),
		.data_rd_en    (data_rd_en),
		.credit_return (credit_return),
		.word_taken    (word_taken),
		.last_word     (last_word)
	);

	tx_beat_format u_beat_format (
		.tx_clk     (tx_clk),
		.rst_n      (rst_n),
		.word_taken (word_taken),
		.last_word  (last_word),
		.word_rd    (word_rd),
		.out_valid  (out_valid),
		.out_beat   (out_beat)
	);

endmodule

// File: source/tx_beat_format.sv
`timescale 1ns/1ps

module tx_beat_format import eth_tx_pkg::*; (
	input  logic     tx_clk,
	input  logic     rst_n,
	input  logic     word_taken,
	input  logic     last_word,
	input  tx_word_t word_rd,
	output logic     out_valid,
	output tx_beat_t out_beat
);

	tx_beat_t beat_next;

	//////////////////////////////////////////////////
	// Byte masking

	always_comb begin
		beat_next.last = last_word;
		for (int i = 0; i < 4; i++) begin
			// Keep covers the low nbytes lanes
			beat_next.keep[i] = (3'(i) < word_rd.nbytes);
			// Lanes past the frame end go out as zero
			beat_next.data[8*i +: 8] = beat_next.keep[i] ? word_rd.data[8*i +: 8] : 8'h00;
		end
	end

	// Valid strobe
	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= word_taken;
	end

	// Beat payload
	always_ff @(posedge tx_clk) begin
		if (word_taken)
			out_beat <= beat_next;
	end

	// Every stored word carries between one and four bytes
	assert property (@(posedge tx_clk) disable iff (!rst_n)
		word_taken |-> (word_rd.nbytes >= 3'd1) && (word_rd.nbytes <= 3'd4))
		else $error("stored word byte count out of range");

endmodule

// File: source/tx_pop_ctrl.sv
`timescale 1ns/1ps

module tx_pop_ctrl import eth_tx_pkg::*; (
	input  logic    tx_clk,
	input  logic    rst_n,
	input  logic    link_up,
	input  logic    len_empty,
	output logic    len_rd_en,
	input  tx_len_t len_rd,
	input  logic    data_empty,
	output logic    data_rd_en,
	input  logic    credit_return,
	output logic    word_taken,
	output logic    last_word
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HDR,
		ST_SEND
	} state_t;

	state_t                 state;
	tx_len_t                words_left;
	logic [CREDIT_BITS-1:0] credits;

	//////////////////////////////////////////////////
	// Pop strobes

	// Header pop straight out of idle
	assign len_rd_en  = (state == ST_IDLE) && link_up && !len_empty;
	// One word per cycle while the MAC has room
	assign data_rd_en = (state == ST_SEND) && link_up && (credits != '0) && !data_empty;

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			words_left <= '0;
			word_taken <= 1'b0;
			last_word  <= 1'b0;
		end else begin
			// Word data is out of the FIFO one cycle after the pop
			word_taken <= data_rd_en;
			last_word  <= data_rd_en && (words_left == LEN_BITS'(1));
			if (!link_up) begin
				state      <= ST_IDLE;
				words_left <= '0;
			end else begin
				case (state)
					ST_IDLE: begin
						if (len_rd_en)
							state <= ST_HDR;
					end
					// Header word count is valid now
					ST_HDR: begin
						words_left <= len_rd;
						state      <= (len_rd != '0) ? ST_SEND : ST_IDLE;
					end
					ST_SEND: begin
						if (data_rd_en) begin
							words_left <= words_left - 1'b1;
							if (words_left == LEN_BITS'(1))
								state <= ST_IDLE;
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Credit counter

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CREDIT_BITS'(TX_CREDITS);
		end else begin
			case ({data_rd_en, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// MAC returns no more credits than it was given
	assert property (@(posedge tx_clk) disable iff (!rst_n)
		credits <= CREDIT_BITS'(TX_CREDITS))
		else $error("credit count above TX_CREDITS");

endmodule

// File: source/tx_fifo.sv
`timescale 1ns/1ps

module tx_fifo #(
	parameter type T     = logic [31:0],
	parameter int  DEPTH = 16
) (
	input  logic tx_clk,
	input  logic rst_n,
	input  logic flush,
	input  logic wr_en,
	input  T     wr_data,
	output logic full,
	input  logic rd_en,
	output T     rd_data,
	output logic empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	T                    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                at_cap;
	logic                push;
	logic                pop;

	//////////////////////////////////////////////////
	// Occupancy

	assign at_cap = (count == CNT_BITS'(DEPTH));
	// Writers push a cycle after checking, so count the push in flight too
	assign full   = at_cap || (wr_en && (count == CNT_BITS'(DEPTH - 1)));
	assign empty  = (count == '0);
	assign push   = wr_en && !flush;
	assign pop    = rd_en && !flush;

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge tx_clk) begin
		if (push)
			mem[wr_ptr] <= wr_data;
		if (pop)
			rd_data <= mem[rd_ptr];
	end

	// Writer must respect full
	assert property (@(posedge tx_clk) disable iff (!rst_n) push |-> !at_cap)
		else $error("tx_fifo push while full");
	// Reader must respect empty
	assert property (@(posedge tx_clk) disable iff (!rst_n) pop |-> !empty)
		else $error("tx_fifo pop while empty");

endmodule

// File: source/tx_reg_port.sv
`timescale 1ns/1ps

module tx_reg_port import eth_tx_pkg::*; (
	input  logic     tx_clk,
	input  logic     rst_n,
	input  reg_req_t req,
	output reg_rsp_t rsp,
	input  logic     link_up,
	input  logic     data_full,
	output logic     word_wr_en,
	output tx_word_t word_wr,
	output logic     len_wr_en,
	output tx_len_t  len_wr
);

	//////////////////////////////////////////////////
	// Access decode

	logic                access;
	logic                wr_access;
	logic                is_commit;
	logic                is_length;
	logic                is_word;
	logic                is_buf;

	// Frame state
	logic [LEN_BITS-1:0] expected_len;
	logic [LEN_BITS-1:0] remaining;
	tx_len_t             word_count;
	tx_len_t             pend_count;
	logic                commit_q;

	// Byte count of the word being written
	logic [LEN_BITS-1:0] wr_offset;
	logic [LEN_BITS-1:0] bytes_left;
	logic [2:0]          push_nbytes;
	logic                in_frame;
	logic                push_ok;

	assign access    = req.sel && req.enable;
	assign wr_access = access && req.write;
	assign is_commit = (req.addr == REG_COMMIT);
	assign is_length = (req.addr == REG_LENGTH);
	assign is_word   = (req.addr == REG_TX_WORD);
	assign is_buf    = (req.addr >= REG_TX_BUF);

	// Window offset is a byte offset into the frame
	assign wr_offset  = LEN_BITS'(req.addr - REG_TX_BUF);
	assign bytes_left = expected_len - wr_offset;

	always_comb begin
		push_nbytes = 3'd0;
		in_frame    = 1'b0;
		if (is_buf) begin
			// Writes past the end of the frame are dropped
			if (wr_offset < expected_len) begin
				in_frame    = 1'b1;
				push_nbytes = (bytes_left >= LEN_BITS'(4)) ? 3'd4 : bytes_left[2:0];
			end
		end else if (is_word) begin
			// Sequential words eat into the remaining count
			if (remaining != '0) begin
				in_frame    = 1'b1;
				push_nbytes = (remaining >= LEN_BITS'(4)) ? 3'd4 : remaining[2:0];
			end
		end
	end

	assign push_ok = wr_access && in_frame && !data_full;

	// Zero wait states
	always_comb begin
		rsp.ready  = access;
		rsp.rdata  = 32'h0;
		rsp.slverr = 1'b0;
		if (access) begin
			if (req.write) begin
				// Status is read only
				if (req.addr == REG_STAT)
					rsp.slverr = 1'b1;
				// Word FIFO full, write is lost
				else if ((is_buf || is_word) && data_full)
					rsp.slverr = 1'b1;
			end else if (req.addr == REG_STAT) begin
				rsp.rdata = {31'h0, link_up};
			end else begin
				// Buffer is write only
				rsp.slverr = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Control state

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			word_wr_en   <= 1'b0;
			len_wr_en    <= 1'b0;
			commit_q     <= 1'b0;
			expected_len <= '0;
			remaining    <= '0;
			word_count   <= '0;
		end else begin
			word_wr_en <= push_ok && link_up;
			// Second commit stage, empty frames never reach the queue
			len_wr_en  <= commit_q && (pend_count != '0) && link_up;
			if (!link_up) begin
				commit_q     <= 1'b0;
				expected_len <= '0;
				remaining    <= '0;
				word_count   <= '0;
			end else if (wr_access && is_commit) begin
				commit_q     <= 1'b1;
				expected_len <= '0;
				remaining    <= '0;
				word_count   <= '0;
			end else begin
				commit_q <= 1'b0;
				if (wr_access && is_length) begin
					expected_len <= req.wdata[LEN_BITS-1:0];
					remaining    <= req.wdata[LEN_BITS-1:0];
				end
				if (push_ok) begin
					word_count <= word_count + 1'b1;
					if (is_word)
						remaining <= remaining - LEN_BITS'(push_nbytes);
				end
			end
		end
	end

	// Payload path
	always_ff @(posedge tx_clk) begin
		if (push_ok) begin
			word_wr.data   <= req.wdata;
			word_wr.nbytes <= push_nbytes;
		end
		// Count snapshot taken on the commit access itself
		if (wr_access && is_commit)
			pend_count <= word_count;
		if (commit_q)
			len_wr <= pend_count;
	end

endmodule

// File: source/eth_tx_pkg.sv
package eth_tx_pkg;

	//////////////////////////////////////////////////
	// Register map

	localparam int REG_ADDR_BITS = 8;

	// Bit 0 reads back the link state
	localparam logic [REG_ADDR_BITS-1:0] REG_STAT    = 8'h00;
	// Any write queues the frame in progress
	localparam logic [REG_ADDR_BITS-1:0] REG_COMMIT  = 8'h20;
	// Expected frame length in bytes
	localparam logic [REG_ADDR_BITS-1:0] REG_LENGTH  = 8'h40;
	// Sequential word write
	localparam logic [REG_ADDR_BITS-1:0] REG_TX_WORD = 8'h60;
	// Buffer window, every address from here up
	localparam logic [REG_ADDR_BITS-1:0] REG_TX_BUF  = 8'h80;

	//////////////////////////////////////////////////
	// Sizes and flow control

	// Byte lengths and word counts, frames up to 2047 bytes
	localparam int LEN_BITS        = 11;
	localparam int DATA_FIFO_DEPTH = 256;
	localparam int LEN_FIFO_DEPTH  = 8;
	// Matches the downstream buffer size
	localparam int TX_CREDITS      = 4;
	localparam int CREDIT_BITS     = $clog2(TX_CREDITS + 1);

	//////////////////////////////////////////////////
	// Shared types

	// Host bus request
	typedef struct packed {
		logic                     sel;
		logic                     enable;
		logic                     write;
		logic [REG_ADDR_BITS-1:0] addr;
		logic [31:0]              wdata;
	} reg_req_t;

	// Host bus response
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
		logic        slverr;
	} reg_rsp_t;

	// Stored word, nbytes is 1 to 4
	typedef struct packed {
		logic [31:0] data;
		logic [2:0]  nbytes;
	} tx_word_t;

	// Word count of one queued frame
	typedef logic [LEN_BITS-1:0] tx_len_t;

	// Output beat toward the MAC
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  keep;
		logic        last;
	} tx_beat_t;

endpackage
